/* design/secp256k1_pkg.sv */
// secp256k1 field definitions
`default_nettype none

package secp256k1_pkg;

  // Field element or operand
  typedef logic [255:0] fe_t;
  // Full double-width product
  typedef logic [511:0] prod_t;
  // One operand half
  typedef logic [127:0] half_t;
  // Sum of two halves, one carry bit wider
  typedef logic [128:0] sum_t;

  // Field prime p = 2^256 - 2^32 - 977
  localparam fe_t P_MOD =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  // 2^256 mod p, used to fold the high half back in
  localparam logic [32:0] FOLD_C = 33'h1_000003D1;

  // Reducer FSM states
  typedef enum logic [1:0] {
    RED_IDLE,
    RED_FOLD,
    RED_SUB,
    RED_HOLD
  } red_state_t;

endpackage

`default_nettype wire

/* design/if_prod_stream.sv */
// Product stream interface
`default_nettype none

interface if_prod_stream import secp256k1_pkg::*; #(
  parameter int CTL_BITS = 8
) (
  input wire i_clk
);

  // Payload
  prod_t               dat;
  logic [CTL_BITS-1:0] ctl;
  logic                err;

  // Handshake, transfer when both are high on a rising edge
  logic                val;
  logic                rdy;

  // Upstream side drives payload and valid
  modport src (
    input  i_clk,
    output dat, ctl, err, val,
    input  rdy
  );

  // Downstream side drives ready
  modport snk (
    input  i_clk,
    input  dat, ctl, err, val,
    output rdy
  );

endinterface

`default_nettype wire

/* design/karatsuba_mult.sv */
// Karatsuba product pipeline
`default_nettype none

module karatsuba_mult import secp256k1_pkg::*; #(
  parameter int CTL_BITS = 8
) (
  input  wire                i_clk,
  input  wire                i_rst,
  input  wire fe_t           i_dat_a,
  input  wire fe_t           i_dat_b,
  input  wire [CTL_BITS-1:0] i_ctl,
  input  wire                i_err,
  input  wire                i_val,
  output logic               o_rdy,
  if_prod_stream.src         o_prod
);

  // Product of the two half sums
  typedef logic [257:0] sq_t;

  logic adv;
  logic s1_val, s2_val, s3_val;

  // Stage 1, halves and half sums
  half_t a_hi1, a_lo1, b_hi1, b_lo1;
  sum_t  a_sum1, b_sum1;
  // Stage 2, the three partial products
  fe_t   hh2, ll2;
  sq_t   ss2;
  // Stage 3 middle term and result
  sq_t   mid;
  prod_t prod3;

  logic [CTL_BITS-1:0] ctl1, ctl2, ctl3;
  logic                err1, err2, err3;

  // Whole pipe moves when the output slot is free or being drained
  always_comb begin
    adv   = !s3_val || o_prod.rdy;
    o_rdy = adv;
    // (a_hi+a_lo)(b_hi+b_lo) - hh - ll
    mid   = ss2 - sq_t'(hh2) - sq_t'(ll2);
  end

  // Valid bits
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
      s3_val <= 1'b0;
    end else if (adv) begin
      s1_val <= i_val;
      s2_val <= s1_val;
      s3_val <= s2_val;
    end
  end

  // Payload registers
  always_ff @(posedge i_clk) begin
    if (adv) begin
      // Split operands, precompute half sums
      a_hi1  <= i_dat_a[255:128];
      a_lo1  <= i_dat_a[127:0];
      b_hi1  <= i_dat_b[255:128];
      b_lo1  <= i_dat_b[127:0];
      a_sum1 <= sum_t'(i_dat_a[255:128]) + sum_t'(i_dat_a[127:0]);
      b_sum1 <= sum_t'(i_dat_b[255:128]) + sum_t'(i_dat_b[127:0]);
      ctl1   <= i_ctl;
      err1   <= i_err;
      // Three multiplies instead of four
      hh2    <= a_hi1 * b_hi1;
      ll2    <= a_lo1 * b_lo1;
      ss2    <= a_sum1 * b_sum1;
      ctl2   <= ctl1;
      err2   <= err1;
      // hh sits in the top half, mid overlaps at bit 128
      prod3  <= {hh2, ll2} + (prod_t'(mid) << 128);
      ctl3   <= ctl2;
      err3   <= err2;
    end
  end

  always_comb begin
    o_prod.dat = prod3;
    o_prod.ctl = ctl3;
    o_prod.err = err3;
    o_prod.val = s3_val;
  end

  // Stalled output must not change under the sink
  a_out_hold: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_prod.val && !o_prod.rdy |=>
      o_prod.val && $stable(o_prod.dat) && $stable(o_prod.ctl) && $stable(o_prod.err)
  );

endmodule

`default_nettype wire

/* design/prod_fifo.sv */
// Product buffer FIFO
`default_nettype none

module prod_fifo import secp256k1_pkg::*; #(
  parameter int CTL_BITS   = 8,
  parameter int FIFO_DEPTH = 4
) (
  input wire         i_clk,
  input wire         i_rst,
  if_prod_stream.snk i_wr,
  if_prod_stream.src o_rd
);

  localparam int AW = $clog2(FIFO_DEPTH);

  // Extra MSB tells full from empty
  typedef logic [AW:0] ptr_t;

  prod_t               dat_mem [FIFO_DEPTH];
  logic [CTL_BITS-1:0] ctl_mem [FIFO_DEPTH];
  logic                err_mem [FIFO_DEPTH];

  ptr_t wr_ptr, rd_ptr;
  logic full, empty;
  logic wr_en, rd_en;

  always_comb begin
    empty = (wr_ptr == rd_ptr);
    // Same slot, different lap
    full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    i_wr.rdy   = !full;
    o_rd.val   = !empty;
    // Head entry is read straight out of the array
    o_rd.dat   = dat_mem[rd_ptr[AW-1:0]];
    o_rd.ctl   = ctl_mem[rd_ptr[AW-1:0]];
    o_rd.err   = err_mem[rd_ptr[AW-1:0]];
    wr_en      = i_wr.val && i_wr.rdy;
    rd_en      = o_rd.val && o_rd.rdy;
  end

  // Storage
  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      dat_mem[wr_ptr[AW-1:0]] <= i_wr.dat;
      ctl_mem[wr_ptr[AW-1:0]] <= i_wr.ctl;
      err_mem[wr_ptr[AW-1:0]] <= i_wr.err;
    end
  end

  // Pointers wrap naturally at 2*depth
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Occupancy never passes the depth, so no write lands on a full buffer
  a_no_overflow: assert property (
    @(posedge i_clk) disable iff (i_rst)
    ptr_t'(wr_ptr - rd_ptr) <= FIFO_DEPTH
  );

  // Sink ready on an empty buffer must not pop anything
  a_no_underflow: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_rd.rdy && !o_rd.val |=> rd_ptr == $past(rd_ptr)
  );

endmodule

`default_nettype wire

/* design/secp256k1_red_p.sv */
// Folding reducer mod p
`default_nettype none

module secp256k1_red_p import secp256k1_pkg::*; #(
  parameter int CTL_BITS = 8
) (
  input  wire                 i_clk,
  input  wire                 i_rst,
  if_prod_stream.snk          i_prod,
  output fe_t                 o_dat,
  output logic [CTL_BITS-1:0] o_ctl,
  output logic                o_err,
  output logic                o_val,
  input  wire                 i_rdy
);

  // 256 bits plus room for a 256x33 bit fold
  localparam int WORK_BITS = 290;

  typedef logic [WORK_BITS-1:0] work_t;

  red_state_t state;

  work_t               work;
  work_t               fold_in;
  work_t               fold_work;
  logic [CTL_BITS-1:0] ctl_r;
  logic                err_r;
  logic                take;
  logic                fits;
  logic                ge_p;

  always_comb begin
    // Accept only when nothing is in flight
    i_prod.rdy = (state == RED_IDLE);
    take       = i_prod.val && i_prod.rdy;
    // First fold straight off the 512 bit product
    fold_in    = work_t'(i_prod.dat[255:0])
               + work_t'(i_prod.dat[511:256]) * work_t'(FOLD_C);
    // Later folds only see a short high part
    fold_work  = work_t'(work[255:0])
               + work_t'(work[WORK_BITS-1:256]) * work_t'(FOLD_C);
    // Value below 2^257
    fits       = !(|work[WORK_BITS-1:257]);
    ge_p       = (work >= work_t'(P_MOD));
  end

  // FSM
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= RED_IDLE;
    end else begin
      case (state)
        RED_IDLE: begin
          if (take) state <= RED_FOLD;
        end
        RED_FOLD: begin
          if (fits) state <= RED_SUB;
        end
        RED_SUB: begin
          if (!ge_p) state <= RED_HOLD;
        end
        RED_HOLD: begin
          // Result leaves on the output handshake
          if (i_rdy) state <= RED_IDLE;
        end
        default: begin
          state <= RED_IDLE;
        end
      endcase
    end
  end

  // Working value, also the output hold register
  always_ff @(posedge i_clk) begin
    case (state)
      RED_IDLE: begin
        if (take) begin
          work  <= fold_in;
          ctl_r <= i_prod.ctl;
          err_r <= i_prod.err;
        end
      end
      RED_FOLD: begin
        if (!fits) work <= fold_work;
      end
      RED_SUB: begin
        // One subtraction per cycle
        if (ge_p) work <= work - work_t'(P_MOD);
      end
      default: begin
        work <= work;
      end
    endcase
  end

  always_comb begin
    o_val = (state == RED_HOLD);
    o_dat = work[255:0];
    o_ctl = ctl_r;
    o_err = err_r;
  end

  // Any result presented is fully reduced
  a_reduced: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_val |-> (o_dat < P_MOD)
  );

endmodule

`default_nettype wire

/* design/secp256k1_mult_mod.sv */
// secp256k1 modular multiplier
`default_nettype none

module secp256k1_mult_mod import secp256k1_pkg::*; #(
  parameter int CTL_BITS   = 8,
  parameter int FIFO_DEPTH = 4
) (
  input  wire                 i_clk,
  input  wire                 i_rst,
  // Operand stream
  input  wire fe_t            i_dat_a,
  input  wire fe_t            i_dat_b,
  input  wire [CTL_BITS-1:0]  i_ctl,
  input  wire                 i_err,
  input  wire                 i_val,
  output logic                o_rdy,
  // Result stream
  output fe_t                 o_dat,
  output logic [CTL_BITS-1:0] o_ctl,
  output logic                o_err,
  output logic                o_val,
  input  wire                 i_rdy
);

  // Multiplier to buffer
  if_prod_stream #(.CTL_BITS(CTL_BITS)) mult_if (i_clk);
  // Buffer to reducer
  if_prod_stream #(.CTL_BITS(CTL_BITS)) red_if (i_clk);

  karatsuba_mult #(
    .CTL_BITS ( CTL_BITS )
  ) u_karatsuba_mult (
    .i_clk   ( i_clk   ),
    .i_rst   ( i_rst   ),
    .i_dat_a ( i_dat_a ),
    .i_dat_b ( i_dat_b ),
    .i_ctl   ( i_ctl   ),
    .i_err   ( i_err   ),
    .i_val   ( i_val   ),
    .o_rdy   ( o_rdy   ),
    .o_prod  ( mult_if )
  );

  // Absorbs reducer stalls so the multiplier keeps streaming
  prod_fifo #(
    .CTL_BITS   ( CTL_BITS   ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_prod_fifo (
    .i_clk ( i_clk   ),
    .i_rst ( i_rst   ),
    .i_wr  ( mult_if ),
    .o_rd  ( red_if  )
  );

  secp256k1_red_p #(
    .CTL_BITS ( CTL_BITS )
  ) u_secp256k1_red_p (
    .i_clk  ( i_clk  ),
    .i_rst  ( i_rst  ),
    .i_prod ( red_if ),
    .o_dat  ( o_dat  ),
    .o_ctl  ( o_ctl  ),
    .o_err  ( o_err  ),
    .o_val  ( o_val  ),
    .i_rdy  ( i_rdy  )
  );

endmodule

`default_nettype wire

/* test/tb_secp256k1_mult_mod.sv */
// Modular multiplier testbench
`default_nettype none

module tb_secp256k1_mult_mod import secp256k1_pkg::*; ();

  localparam int NUM_OPS        = 200;
  localparam int NUM_EDGE       = 16;
  localparam int STALL_AT       = 100;
  localparam int STALL_CYCLES   = 40;
  localparam int TIMEOUT_CYCLES = 20000;

  // Field prime p = 2^256 - 2^32 - 977
  localparam prod_t FIELD_P = (prod_t'(1) << 256) - (prod_t'(1) << 32) - prod_t'(977);

  logic       i_clk, i_rst;
  fe_t        i_dat_a, i_dat_b;
  logic [7:0] i_ctl;
  logic       i_err, i_val, o_rdy;
  fe_t        o_dat;
  logic [7:0] o_ctl;
  logic       o_err, o_val, i_rdy;

  // Expected results in input order
  fe_t        exp_dat_q[$];
  logic [7:0] exp_ctl_q[$];
  logic       exp_err_q[$];
  logic       head_ok, head_err;
  fe_t        head_dat;
  logic [7:0] head_ctl;

  logic in_fire, out_fire;
  int   seed, loaded_cnt, out_cnt, cycle_cnt;

  secp256k1_mult_mod #(
    .CTL_BITS   ( 8 ),
    .FIFO_DEPTH ( 4 )
  ) u_secp256k1_mult_mod (
    .i_clk   ( i_clk   ),
    .i_rst   ( i_rst   ),
    .i_dat_a ( i_dat_a ),
    .i_dat_b ( i_dat_b ),
    .i_ctl   ( i_ctl   ),
    .i_err   ( i_err   ),
    .i_val   ( i_val   ),
    .o_rdy   ( o_rdy   ),
    .o_dat   ( o_dat   ),
    .o_ctl   ( o_ctl   ),
    .o_err   ( o_err   ),
    .o_val   ( o_val   ),
    .i_rdy   ( i_rdy   )
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "Stopped at the first failing check");
  endtask

  // Full 512 bit product reduced with a true modulo
  function automatic fe_t mul_mod_p(input fe_t a, input fe_t b);
    prod_t full;
    full = prod_t'(a) * prod_t'(b);
    return fe_t'(full % FIELD_P);
  endfunction

  function automatic bit chance(input int pct);
    int unsigned roll;
    roll = $unsigned($random(seed)) % 32'd100;
    return roll < pct;
  endfunction

  // Random operand already below p
  function automatic fe_t rand_fe();
    fe_t v;
    int  i;
    for (i = 0; i < 8; i++) v[i*32 +: 32] = $random(seed);
    return fe_t'(prod_t'(v) % FIELD_P);
  endfunction

  // Corner operands with the unreduced all-ones value last
  function automatic fe_t edge_val(input int idx);
    case (idx)
      0:       return '0;
      1:       return fe_t'(1);
      2:       return fe_t'(FIELD_P - prod_t'(1));
      default: return '1;
    endcase
  endfunction

  task automatic load_next_op();
    if (loaded_cnt < NUM_EDGE) begin
      i_dat_a = edge_val(loaded_cnt / 4);
      i_dat_b = edge_val(loaded_cnt % 4);
    end else begin
      i_dat_a = rand_fe();
      i_dat_b = rand_fe();
    end
    // Tag is the op number, so ordering errors show up on o_ctl
    i_ctl = loaded_cnt[7:0];
    i_err = chance(50);
    i_val = 1'b1;
    loaded_cnt++;
  endtask

  task automatic update_head();
    head_ok = (exp_dat_q.size() != 0);
    if (head_ok) begin
      head_dat = exp_dat_q[0];
      head_ctl = exp_ctl_q[0];
      head_err = exp_err_q[0];
    end
  endtask

  // Scoreboard update first and new drive values after it
  task automatic run_cycle(input int val_pct, input int rdy_pct);
    @(posedge i_clk);
    #1;
    if (out_fire) begin
      void'(exp_dat_q.pop_front());
      void'(exp_ctl_q.pop_front());
      void'(exp_err_q.pop_front());
      out_cnt++;
    end
    if (in_fire) begin
      exp_dat_q.push_back(mul_mod_p(i_dat_a, i_dat_b));
      exp_ctl_q.push_back(i_ctl);
      exp_err_q.push_back(i_err);
    end
    update_head();
    // An offered op stays put until it is taken
    if (!i_val || in_fire) begin
      if (loaded_cnt < NUM_OPS && chance(val_pct)) load_next_op();
      else i_val = 1'b0;
    end
    i_rdy = chance(rdy_pct);
  endtask

  // Handshakes sampled mid cycle where both sides are settled
  always @(negedge i_clk) begin
    in_fire  = !i_rst && i_val && o_rdy;
    out_fire = !i_rst && o_val && i_rdy;
  end

  a_reset_state: assert property (@(posedge i_clk) $fell(i_rst) |-> !o_val && o_rdy)
    else fail_run("Output valid high or input ready low in the first cycle after reset");

  a_expected: assert property (@(posedge i_clk) disable iff (i_rst) o_val |-> head_ok)
    else fail_run("A result came out while no result was pending");

  a_dat: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && head_ok |-> o_dat == head_dat)
    else fail_run($sformatf("Error: o_dat expected %h got %h",
                            $sampled(head_dat), $sampled(o_dat)));

  a_ctl: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && head_ok |-> o_ctl == head_ctl)
    else fail_run($sformatf("Error: o_ctl expected %h got %h",
                            $sampled(head_ctl), $sampled(o_ctl)));

  a_err: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && head_ok |-> o_err == head_err)
    else fail_run($sformatf("Error: o_err expected %h got %h",
                            $sampled(head_err), $sampled(o_err)));

  // Stalled result must sit still
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_dat) && $stable(o_ctl) && $stable(o_err))
    else fail_run($sformatf("Error: stalled output changed, o_val %h o_dat %h o_ctl %h",
                            $sampled(o_val), $sampled(o_dat), $sampled(o_ctl)));

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_cnt++;
    end
    fail_run($sformatf("Run timed out after %0d cycles", cycle_cnt));
  end

  initial begin
    seed       = 46;
    i_rst      = 1'b1;
    i_dat_a    = '0;
    i_dat_b    = '0;
    i_ctl      = '0;
    i_err      = 1'b0;
    i_val      = 1'b0;
    i_rdy      = 1'b0;
    head_ok    = 1'b0;
    in_fire    = 1'b0;
    out_fire   = 1'b0;
    loaded_cnt = 0;
    out_cnt    = 0;
    repeat (3) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    // Edge pairings first and random traffic after them
    while (loaded_cnt < STALL_AT) run_cycle(70, 70);
    // Long output stall fills reducer, FIFO and pipeline
    repeat (STALL_CYCLES) run_cycle(100, 0);
    a_stall: assert (!o_rdy)
      else fail_run("Input ready stayed high through a long output stall");
    while (loaded_cnt < NUM_OPS || i_val) run_cycle(70, 70);
    while (exp_dat_q.size() != 0) run_cycle(0, 70);
    // Any extra result in the quiet tail trips a_expected
    repeat (20) run_cycle(0, 100);
    if (exp_dat_q.size() != 0 || out_cnt != NUM_OPS) begin
      fail_run($sformatf("Wrong number of results, %0d of %0d", out_cnt, NUM_OPS));
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* secp256k1_mult_mod.f */
design/secp256k1_pkg.sv
design/if_prod_stream.sv
design/karatsuba_mult.sv
design/prod_fifo.sv
design/secp256k1_red_p.sv
design/secp256k1_mult_mod.sv
test/tb_secp256k1_mult_mod.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_secp256k1_mult_mod \
  -f secp256k1_mult_mod.f -Mdir obj_dir &&
./obj_dir/Vtb_secp256k1_mult_mod ||
{ echo "simulation failed"; exit 1; }
